// ==== verilog/sysmem_defs.svh ====
`ifndef SYSMEM_DEFS_SVH
`define SYSMEM_DEFS_SVH

// one controller data lane
`define SYSMEM_LANE_W 64
`define SYSMEM_BE_W 8

// host burst length field
`define SYSMEM_BURST_W 8

// controller command and write lane words
`define SYSMEM_CMD_W 60
`define SYSMEM_WR_W 90

// host word addresses
`define SYSMEM_RAM_ADDR_W 29
`define SYSMEM_VBUF_ADDR_W 28

// power-up hold, short enough for simulation
`define SYSMEM_INIT_CYCLES 32

`endif

// ==== verilog/sysmem_pkg.sv ====
`include "sysmem_defs.svh"

package sysmem_pkg;

	// 29-bit address layout, used by the 64-bit port
	typedef struct packed {
		logic [`SYSMEM_CMD_W-43:0]      zero_hi;
		logic [`SYSMEM_BURST_W-1:0]     burstcount;
		logic [2:0]                     zero_mid;
		logic [`SYSMEM_RAM_ADDR_W-1:0]  address;
		logic                           write;
		logic                           read;
	} sysmem_cmd_wide_t;

	// 28-bit address layout, used by the two-lane port
	typedef struct packed {
		logic [`SYSMEM_CMD_W-43:0]      zero_hi;
		logic [`SYSMEM_BURST_W-1:0]     burstcount;
		logic [3:0]                     zero_mid;
		logic [`SYSMEM_VBUF_ADDR_W-1:0] address;
		logic                           write;
		logic                           read;
	} sysmem_cmd_narrow_t;

	// one command word, two decodings
	typedef union packed {
		sysmem_cmd_wide_t   wide;
		sysmem_cmd_narrow_t narrow;
	} sysmem_cmd_t;

endpackage

// ==== verilog/sysmem_reset_ctrl.sv ====
`timescale 1ns/1ps

`include "sysmem_defs.svh"

module sysmem_reset_ctrl (
	input  logic clock,
	input  logic rst_n,
	input  logic reset_core_req,
	output logic reset_out
);

	localparam int cnt_w = $clog2(`SYSMEM_INIT_CYCLES + 1);

	logic [cnt_w-1:0] hold_cnt;
	logic             hold_done;
	logic [1:0]       core_sync;

	//////////////////////////////////////////////////
	// power-up hold
	//////////////////////////////////////////////////

	assign hold_done = (hold_cnt == cnt_w'(`SYSMEM_INIT_CYCLES));

	// counts up once, then sits at the end value
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			hold_cnt <= '0;
		end else if (!hold_done) begin
			hold_cnt <= hold_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// core reset request
	//////////////////////////////////////////////////

	// request comes from another domain
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			core_sync <= 2'b00;
		end else begin
			core_sync <= {core_sync[0], reset_core_req};
		end
	end

	assign reset_out = !hold_done || core_sync[1];

endmodule

// ==== verilog/sysmem_port.sv ====
`timescale 1ns/1ps

`include "sysmem_defs.svh"

module sysmem_port #(
	parameter int lanes = 1
) (
	input  logic clock,
	input  logic rst_n,
	input  logic term_req,

	// host side
	input  logic [((lanes > 1) ? `SYSMEM_VBUF_ADDR_W : `SYSMEM_RAM_ADDR_W)-1:0] address,
	input  logic [`SYSMEM_BURST_W-1:0]            burstcount,
	input  logic                                  read,
	input  logic                                  write,
	input  logic [lanes*`SYSMEM_LANE_W-1:0]       writedata,
	input  logic [lanes*`SYSMEM_BE_W-1:0]         byteenable,
	output logic                                  waitrequest,
	output logic [lanes*`SYSMEM_LANE_W-1:0]       readdata,
	output logic                                  readdatavalid,

	// controller side
	input  logic                                  cmd_ready,
	input  logic                                  rd_valid,
	input  logic [lanes-1:0][`SYSMEM_LANE_W-1:0]  rd_data,
	output logic                                  cmd_valid,
	output sysmem_pkg::sysmem_cmd_t               cmd_data,
	output logic                                  wr_valid,
	output logic [lanes-1:0][`SYSMEM_WR_W-1:0]    wr_data
);

	import sysmem_pkg::*;

	localparam int be_w = lanes * `SYSMEM_BE_W;
	// room for several outstanding read bursts
	localparam int owed_w = `SYSMEM_BURST_W + 4;

	logic [`SYSMEM_BURST_W-1:0] wr_left;
	logic                       in_burst;
	logic [owed_w-1:0]          rd_owed;
	logic                       discard_q;
	logic                       gate;
	logic                       flush;
	logic                       wr_beat;
	logic                       rd_acc;
	logic                       rd_dec;
	logic [be_w-1:0]            be_eff;
	sysmem_cmd_t                cmd_word;

	//////////////////////////////////////////////////
	// host gating
	//////////////////////////////////////////////////

	// termination, plus draining of reads still owed from before it
	assign gate     = term_req || (discard_q && (rd_owed != '0));
	assign in_burst = (wr_left != '0);
	assign flush    = gate && in_burst;

	assign waitrequest   = !cmd_ready || gate;
	assign readdatavalid = rd_valid && !gate;
	assign readdata      = rd_data;

	// only the first beat of a write burst carries a command
	assign cmd_valid = !gate && (read || (write && !in_burst));

	// while gated the port finishes a partial burst on its own
	assign wr_valid = gate ? in_burst : write;

	assign wr_beat = wr_valid && cmd_ready;
	assign rd_acc  = read && !waitrequest;
	assign rd_dec  = rd_valid && (rd_owed != '0);

	//////////////////////////////////////////////////
	// beat counters
	//////////////////////////////////////////////////

	// beats still owed in the current write burst
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_left <= '0;
		end else if (wr_beat) begin
			if (in_burst) begin
				wr_left <= wr_left - 1'b1;
			end else if (burstcount != '0) begin
				wr_left <= burstcount - 1'b1;
			end
		end
	end

	// read beats requested but not yet returned
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rd_owed <= '0;
		end else begin
			rd_owed <= rd_owed + (rd_acc ? owed_w'(burstcount) : '0)
				- (rd_dec ? owed_w'(1) : '0);
		end
	end

	// keeps swallowing read data after a termination until none is owed
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			discard_q <= 1'b0;
		end else if (term_req) begin
			discard_q <= 1'b1;
		end else if (rd_owed == '0) begin
			discard_q <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// command and lane packing
	//////////////////////////////////////////////////

	if (lanes > 1) begin : g_narrow
		always_comb begin
			cmd_word                   = '0;
			cmd_word.narrow.read       = read;
			cmd_word.narrow.write      = write;
			cmd_word.narrow.address    = address;
			cmd_word.narrow.burstcount = burstcount;
		end
	end else begin : g_wide
		always_comb begin
			cmd_word                 = '0;
			cmd_word.wide.read       = read;
			cmd_word.wide.write      = write;
			cmd_word.wide.address    = address;
			cmd_word.wide.burstcount = burstcount;
		end
	end

	assign cmd_data = cmd_word;

	// filler beats write nothing
	assign be_eff = flush ? '0 : byteenable;

	// lane 0 takes the low half of the host word
	always_comb begin
		for (int i = 0; i < lanes; i++) begin
			wr_data[i] = '0;
			wr_data[i][80 +: `SYSMEM_BE_W] = be_eff[i*`SYSMEM_BE_W +: `SYSMEM_BE_W];
			wr_data[i][`SYSMEM_LANE_W-1:0] = writedata[i*`SYSMEM_LANE_W +: `SYSMEM_LANE_W];
		end
	end

endmodule

// ==== verilog/sysmem_lite.sv ====
`timescale 1ns/1ps

`include "sysmem_defs.svh"

module sysmem_lite (
	input  logic clock,
	input  logic rst_n,
	input  logic reset_core_req,
	output logic reset_out,

	// ram host port
	input  logic [`SYSMEM_RAM_ADDR_W-1:0]     ram_address,
	input  logic [`SYSMEM_BURST_W-1:0]        ram_burstcount,
	input  logic                              ram_read,
	input  logic                              ram_write,
	input  logic [`SYSMEM_LANE_W-1:0]         ram_writedata,
	input  logic [`SYSMEM_BE_W-1:0]           ram_byteenable,
	output logic                              ram_waitrequest,
	output logic [`SYSMEM_LANE_W-1:0]         ram_readdata,
	output logic                              ram_readdatavalid,

	// vbuf host port, two lanes wide
	input  logic [`SYSMEM_VBUF_ADDR_W-1:0]    vbuf_address,
	input  logic [`SYSMEM_BURST_W-1:0]        vbuf_burstcount,
	input  logic                              vbuf_read,
	input  logic                              vbuf_write,
	input  logic [2*`SYSMEM_LANE_W-1:0]       vbuf_writedata,
	input  logic [2*`SYSMEM_BE_W-1:0]         vbuf_byteenable,
	output logic                              vbuf_waitrequest,
	output logic [2*`SYSMEM_LANE_W-1:0]       vbuf_readdata,
	output logic                              vbuf_readdatavalid,

	// controller lanes for ram
	input  logic                              ram_cmd_ready,
	input  logic                              ram_rd_valid,
	input  logic [`SYSMEM_LANE_W-1:0]         ram_rd_data,
	output logic                              ram_cmd_valid,
	output sysmem_pkg::sysmem_cmd_t           ram_cmd_data,
	output logic                              ram_wr_valid,
	output logic [`SYSMEM_WR_W-1:0]           ram_wr_data,

	// controller lanes for vbuf
	input  logic                              vbuf_cmd_ready,
	input  logic                              vbuf_rd_valid,
	input  logic [1:0][`SYSMEM_LANE_W-1:0]    vbuf_rd_data,
	output logic                              vbuf_cmd_valid,
	output sysmem_pkg::sysmem_cmd_t           vbuf_cmd_data,
	output logic                              vbuf_wr_valid,
	output logic [1:0][`SYSMEM_WR_W-1:0]      vbuf_wr_data
);

	//////////////////////////////////////////////////
	// reset control
	//////////////////////////////////////////////////

	sysmem_reset_ctrl u_reset_ctrl (
		.clock          (clock),
		.rst_n          (rst_n),
		.reset_core_req (reset_core_req),
		.reset_out      (reset_out)
	);

	//////////////////////////////////////////////////
	// ports, both terminated by the same reset
	//////////////////////////////////////////////////

	sysmem_port #(
		.lanes (1)
	) u_ram_port (
		.clock         (clock),
		.rst_n         (rst_n),
		.term_req      (reset_out),
		.address       (ram_address),
		.burstcount    (ram_burstcount),
		.read          (ram_read),
		.write         (ram_write),
		.writedata     (ram_writedata),
		.byteenable    (ram_byteenable),
		.waitrequest   (ram_waitrequest),
		.readdata      (ram_readdata),
		.readdatavalid (ram_readdatavalid),
		.cmd_ready     (ram_cmd_ready),
		.rd_valid      (ram_rd_valid),
		.rd_data       (ram_rd_data),
		.cmd_valid     (ram_cmd_valid),
		.cmd_data      (ram_cmd_data),
		.wr_valid      (ram_wr_valid),
		.wr_data       (ram_wr_data)
	);

	sysmem_port #(
		.lanes (2)
	) u_vbuf_port (
		.clock         (clock),
		.rst_n         (rst_n),
		.term_req      (reset_out),
		.address       (vbuf_address),
		.burstcount    (vbuf_burstcount),
		.read          (vbuf_read),
		.write         (vbuf_write),
		.writedata     (vbuf_writedata),
		.byteenable    (vbuf_byteenable),
		.waitrequest   (vbuf_waitrequest),
		.readdata      (vbuf_readdata),
		.readdatavalid (vbuf_readdatavalid),
		.cmd_ready     (vbuf_cmd_ready),
		.rd_valid      (vbuf_rd_valid),
		.rd_data       (vbuf_rd_data),
		.cmd_valid     (vbuf_cmd_valid),
		.cmd_data      (vbuf_cmd_data),
		.wr_valid      (vbuf_wr_valid),
		.wr_data       (vbuf_wr_data)
	);

endmodule

// ==== verif/sysmem_tb.sv ====
`timescale 1ns/1ps

`include "sysmem_defs.svh"

module sysmem_tb;

	import sysmem_pkg::*;

	localparam int clk_period = 20;
	// rough sum of all test lengths in clocks
	localparam int test_cycles = 120;

	logic clock, rst_n, reset_core_req, reset_out;
	logic [`SYSMEM_RAM_ADDR_W-1:0] ram_address;
	logic [`SYSMEM_VBUF_ADDR_W-1:0] vbuf_address;
	logic [`SYSMEM_BURST_W-1:0] ram_burstcount, vbuf_burstcount;
	logic ram_read, ram_write, vbuf_read, vbuf_write;
	logic ram_waitrequest, ram_readdatavalid, vbuf_waitrequest, vbuf_readdatavalid;
	logic [`SYSMEM_LANE_W-1:0] ram_writedata, ram_readdata, ram_rd_data;
	logic [2*`SYSMEM_LANE_W-1:0] vbuf_writedata, vbuf_readdata;
	logic [`SYSMEM_BE_W-1:0] ram_byteenable;
	logic [2*`SYSMEM_BE_W-1:0] vbuf_byteenable;
	logic ram_cmd_ready, ram_rd_valid, ram_cmd_valid, ram_wr_valid;
	logic vbuf_cmd_ready, vbuf_rd_valid, vbuf_cmd_valid, vbuf_wr_valid;
	logic [1:0][`SYSMEM_LANE_W-1:0] vbuf_rd_data;
	logic [`SYSMEM_WR_W-1:0] ram_wr_data;
	logic [1:0][`SYSMEM_WR_W-1:0] vbuf_wr_data;
	sysmem_cmd_t ram_cmd_data, vbuf_cmd_data;

	int checks = 0;
	int errors = 0;

	sysmem_lite u_sysmem_lite (.*);

	initial begin
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	initial begin
		#(5 * test_cycles * clk_period);
		$display("watchdog expired after %0d clocks, run stopped", 5 * test_cycles);
		$display("Test failures found");
		$finish;
	end

	//////////////////////////////////////////////////
	// check helpers
	//////////////////////////////////////////////////

	task check_value(input string name, input logic [127:0] exp, input logic [127:0] got);
		checks++;
		if (exp !== got) begin
			errors++;
			$display("FAILED %s expected %h got %h", name, exp, got);
		end
	endtask

	// expected word built from the documented bit positions
	task check_cmd(input string name, input sysmem_cmd_t got, input logic narrow,
			input logic [28:0] addr, input logic [7:0] burst, input logic rd, input logic wr);
		logic [`SYSMEM_CMD_W-1:0] exp;
		exp = '0;
		exp[0] = rd;
		exp[1] = wr;
		if (narrow) begin
			exp[29:2] = addr[27:0];
			check_value({name, ".narrow.address"}, addr[27:0], got.narrow.address);
		end else begin
			exp[30:2] = addr;
			check_value({name, ".wide.address"}, addr, got.wide.address);
		end
		exp[41:34] = burst;
		check_value({name, " burstcount"}, burst,
			narrow ? got.narrow.burstcount : got.wide.burstcount);
		check_value(name, exp, got);
	endtask

	// called at a sample point and steps one clock at a time
	task wait_reset_out(input logic level);
		int n;
		n = 0;
		while (reset_out !== level && n < `SYSMEM_INIT_CYCLES + 4) begin
			@(negedge clock);
			#1;
			n++;
		end
		if (reset_out !== level) begin
			errors++;
			$display("reset_out did not reach %0d within %0d clocks", level, n);
		end
	endtask

	task finish_test(input string name, input int errs0);
		if (errors == errs0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - errs0);
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task power_up_hold;
		int errs0;
		int n;
		errs0 = errors;
		n = 0;
		rst_n = 1'b1;
		#1;
		check_value("reset_out", 1, reset_out);
		while (reset_out && n < `SYSMEM_INIT_CYCLES + 2) begin
			check_value("ram_cmd_valid", 0, ram_cmd_valid);
			check_value("vbuf_cmd_valid", 0, vbuf_cmd_valid);
			check_value("ram_waitrequest", 1, ram_waitrequest);
			check_value("vbuf_waitrequest", 1, vbuf_waitrequest);
			@(negedge clock);
			// early reads must stay blocked by the hold
			ram_read = (n < 16);
			vbuf_read = (n < 16);
			#1;
			n++;
		end
		if (reset_out) begin
			errors++;
			$display("reset_out still high %0d clocks after reset release", n);
		end
		finish_test("power-up hold", errs0);
	endtask

	task ram_write_burst;
		int errs0;
		logic [28:0] addr;
		logic [63:0] data;
		logic [7:0] be;
		errs0 = errors;
		addr = 29'($urandom);
		for (int beat = 0; beat < 3; beat++) begin
			@(negedge clock);
			data = {$urandom, $urandom};
			be = 8'($urandom);
			ram_write = 1'b1;
			ram_address = addr;
			ram_burstcount = 8'd3;
			ram_writedata = data;
			ram_byteenable = be;
			ram_cmd_ready = (beat != 1);
			#1;
			if (beat == 1) begin
				check_value("ram_waitrequest", 1, ram_waitrequest);
				@(negedge clock);
				ram_cmd_ready = 1'b1;
				#1;
			end
			check_value("ram_waitrequest", 0, ram_waitrequest);
			check_value("ram_wr_valid", 1, ram_wr_valid);
			check_value("ram_wr_data", {2'b00, be, 16'h0000, data}, ram_wr_data);
			check_value("ram_cmd_valid", beat == 0, ram_cmd_valid);
			if (beat == 0) begin
				check_cmd("ram_cmd_data", ram_cmd_data, 1'b0, addr, 8'd3, 1'b0, 1'b1);
			end
		end
		@(negedge clock);
		ram_write = 1'b0;
		finish_test("ram write burst", errs0);
	endtask

	task vbuf_lane_write;
		int errs0;
		logic [27:0] addr;
		logic [127:0] data;
		logic [15:0] be;
		errs0 = errors;
		addr = 28'($urandom);
		data = {$urandom, $urandom, $urandom, $urandom};
		be = 16'($urandom);
		@(negedge clock);
		vbuf_write = 1'b1;
		vbuf_address = addr;
		vbuf_burstcount = 8'd1;
		vbuf_writedata = data;
		vbuf_byteenable = be;
		#1;
		check_value("vbuf_cmd_valid", 1, vbuf_cmd_valid);
		check_cmd("vbuf_cmd_data", vbuf_cmd_data, 1'b1, {1'b0, addr}, 8'd1, 1'b0, 1'b1);
		check_value("vbuf_wr_valid", 1, vbuf_wr_valid);
		check_value("vbuf_wr_data[0]", {2'b00, be[7:0], 16'h0000, data[63:0]},
			vbuf_wr_data[0]);
		check_value("vbuf_wr_data[1]", {2'b00, be[15:8], 16'h0000, data[127:64]},
			vbuf_wr_data[1]);
		@(negedge clock);
		vbuf_write = 1'b0;
		finish_test("vbuf write", errs0);
	endtask

	// both ports read in the same clocks
	task both_port_reads;
		int errs0;
		logic [28:0] ram_addr;
		logic [27:0] vbuf_addr;
		logic [63:0] lane0, lane1, ram_lane;
		errs0 = errors;
		ram_addr = 29'($urandom);
		vbuf_addr = 28'($urandom);
		@(negedge clock);
		ram_read = 1'b1;
		ram_address = ram_addr;
		ram_burstcount = 8'd1;
		vbuf_read = 1'b1;
		vbuf_address = vbuf_addr;
		vbuf_burstcount = 8'd1;
		#1;
		check_value("ram_cmd_valid", 1, ram_cmd_valid);
		check_value("vbuf_cmd_valid", 1, vbuf_cmd_valid);
		check_cmd("ram_cmd_data", ram_cmd_data, 1'b0, ram_addr, 8'd1, 1'b1, 1'b0);
		check_cmd("vbuf_cmd_data", vbuf_cmd_data, 1'b1, {1'b0, vbuf_addr}, 8'd1, 1'b1, 1'b0);
		@(negedge clock);
		ram_read = 1'b0;
		vbuf_read = 1'b0;
		ram_lane = {$urandom, $urandom};
		lane0 = {$urandom, $urandom};
		lane1 = {$urandom, $urandom};
		ram_rd_valid = 1'b1;
		ram_rd_data = ram_lane;
		vbuf_rd_valid = 1'b1;
		vbuf_rd_data[0] = lane0;
		vbuf_rd_data[1] = lane1;
		#1;
		check_value("ram_readdatavalid", 1, ram_readdatavalid);
		check_value("ram_readdata", ram_lane, ram_readdata);
		check_value("vbuf_readdatavalid", 1, vbuf_readdatavalid);
		check_value("vbuf_readdata", {lane1, lane0}, vbuf_readdata);
		@(negedge clock);
		ram_rd_valid = 1'b0;
		vbuf_rd_valid = 1'b0;
		finish_test("reads", errs0);
	endtask

	task terminated_write;
		int errs0;
		int beats;
		errs0 = errors;
		beats = 0;
		@(negedge clock);
		ram_write = 1'b1;
		ram_address = 29'($urandom);
		ram_burstcount = 8'd4;
		ram_writedata = {$urandom, $urandom};
		ram_byteenable = 8'hff;
		@(negedge clock);
		// burst left hanging with 3 beats owed
		ram_write = 1'b0;
		reset_core_req = 1'b1;
		#1;
		wait_reset_out(1'b1);
		check_value("ram_waitrequest", 1, ram_waitrequest);
		for (int i = 0; i < 8; i++) begin
			if (i > 0) begin
				@(negedge clock);
				// a new host request must not issue a command
				ram_read = 1'b1;
				#1;
			end
			check_value("ram_cmd_valid", 0, ram_cmd_valid);
			if (ram_wr_valid) begin
				beats++;
				check_value("ram_wr_data byteenable", 0, ram_wr_data[87:80]);
			end
		end
		check_value("ram_wr_valid beats", 3, beats);
		@(negedge clock);
		ram_read = 1'b0;
		reset_core_req = 1'b0;
		#1;
		wait_reset_out(1'b0);
		finish_test("terminated write", errs0);
	endtask

	task terminated_read;
		int errs0;
		logic [63:0] lane;
		errs0 = errors;
		@(negedge clock);
		ram_read = 1'b1;
		ram_address = 29'($urandom);
		ram_burstcount = 8'd2;
		#1;
		check_value("ram_cmd_valid", 1, ram_cmd_valid);
		@(negedge clock);
		ram_read = 1'b0;
		reset_core_req = 1'b1;
		#1;
		wait_reset_out(1'b1);
		// both owed beats arrive during the reset
		repeat (2) begin
			@(negedge clock);
			ram_rd_valid = 1'b1;
			ram_rd_data = {$urandom, $urandom};
			#1;
			check_value("ram_readdatavalid", 0, ram_readdatavalid);
			@(negedge clock);
			ram_rd_valid = 1'b0;
		end
		reset_core_req = 1'b0;
		#1;
		wait_reset_out(1'b0);
		@(negedge clock);
		ram_read = 1'b1;
		ram_burstcount = 8'd1;
		#1;
		check_value("ram_waitrequest", 0, ram_waitrequest);
		check_value("ram_cmd_valid", 1, ram_cmd_valid);
		@(negedge clock);
		lane = {$urandom, $urandom};
		ram_read = 1'b0;
		ram_rd_valid = 1'b1;
		ram_rd_data = lane;
		#1;
		check_value("ram_readdatavalid", 1, ram_readdatavalid);
		check_value("ram_readdata", lane, ram_readdata);
		@(negedge clock);
		ram_rd_valid = 1'b0;
		finish_test("terminated read", errs0);
	endtask

	initial begin
		void'($urandom(35));
		rst_n = 1'b0;
		reset_core_req = 1'b0;
		{ram_address, ram_burstcount, ram_read, ram_write} = '0;
		{ram_writedata, ram_byteenable, ram_rd_valid, ram_rd_data} = '0;
		{vbuf_address, vbuf_burstcount, vbuf_read, vbuf_write} = '0;
		{vbuf_writedata, vbuf_byteenable, vbuf_rd_valid, vbuf_rd_data} = '0;
		ram_cmd_ready = 1'b1;
		vbuf_cmd_ready = 1'b1;
		repeat (4) @(negedge clock);
		power_up_hold();
		ram_write_burst();
		vbuf_lane_write();
		both_port_reads();
		terminated_write();
		terminated_read();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/sysmem_pkg.sv
verilog/sysmem_reset_ctrl.sv
verilog/sysmem_port.sv
verilog/sysmem_lite.sv
verif/sysmem_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module sysmem_tb -f list.f
	@out="$$(./obj_dir/Vsysmem_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "All tests passed!"

clean:
	rm -rf obj_dir
